/* design/fu_status_table.sv */
`timescale 1ns/10ps

module fu_status_table #(
    parameter int REG_COUNT = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  sb_pkg::issue_req_t req,
    input  logic              issue_valid,
    input  sb_pkg::fu_done_t  fu_done,
    output logic              hazard,
    output sb_pkg::fu_e       ro_fu,
    output sb_pkg::fu_entry_t ro_entry,
    output sb_pkg::xlen_t     ro_pc,
    output sb_pkg::xlen_t     ro_imm,
    output sb_pkg::fu_e       wb_fu,
    output sb_pkg::fu_entry_t wb_entry
);
    import sb_pkg::*;

    localparam int IDX_W = $clog2(REG_COUNT);
    localparam fu_e PRIO [4] = '{FU_JUMP, FU_ALU, FU_MEM, FU_MUL};   // grant order

    fu_entry_t fus  [FU_ALU:FU_JUMP];
    xlen_t     pcr  [FU_ALU:FU_JUMP];
    xlen_t     immr [FU_ALU:FU_JUMP];
    fu_e       rrs  [REG_COUNT];        // pending producer per register
    logic      done_in [FU_ALU:FU_JUMP];
    logic      war_ok  [FU_ALU:FU_JUMP];
    fu_e       src1_fu;
    fu_e       src2_fu;
    fu_e       dst_fu;
    fu_entry_t new_entry;

    assign done_in[FU_ALU]  = fu_done.alu;
    assign done_in[FU_MEM]  = fu_done.mem;
    assign done_in[FU_MUL]  = fu_done.mul;
    assign done_in[FU_JUMP] = fu_done.jump;

    assign src1_fu = rrs[req.src1[IDX_W-1:0]];
    assign src2_fu = rrs[req.src2[IDX_W-1:0]];
    assign dst_fu  = rrs[req.dst[IDX_W-1:0]];

    // structural or waw
    assign hazard = ((req.fu != FU_NONE) && fus[req.fu].busy) || (dst_fu != FU_NONE);

    // a producer writing back at this edge counts as already done
    always_comb begin
        new_entry      = '0;
        new_entry.busy = 1'b1;
        new_entry.op   = req.op;
        new_entry.dst  = req.dst;
        new_entry.src1 = req.src1;
        new_entry.src2 = req.src2;
        new_entry.rdy1 = (src1_fu == FU_NONE) || (src1_fu == wb_fu);
        new_entry.rdy2 = (src2_fu == FU_NONE) || (src2_fu == wb_fu);
        new_entry.fu1  = new_entry.rdy1 ? FU_NONE : src1_fu;
        new_entry.fu2  = new_entry.rdy2 ? FU_NONE : src2_fu;
    end

    // war: hold a write while some reader still has the old value pending
    always_comb begin
        for (int w = FU_ALU; w <= FU_JUMP; w++) begin
            war_ok[w] = 1'b1;
            for (int r = FU_ALU; r <= FU_JUMP; r++) begin
                if (fus[w].dst != '0 && fus[r].rdy1 && fus[r].src1 == fus[w].dst) begin
                    war_ok[w] = 1'b0;
                end
                if (fus[w].dst != '0 && fus[r].rdy2 && fus[r].src2 == fus[w].dst) begin
                    war_ok[w] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        ro_fu = FU_NONE;
        wb_fu = FU_NONE;
        for (int i = 3; i >= 0; i--) begin   // highest priority assigned last
            if (fus[PRIO[i]].rdy1 && fus[PRIO[i]].rdy2) begin
                ro_fu = PRIO[i];
            end
            if (fus[PRIO[i]].done && war_ok[PRIO[i]]) begin
                wb_fu = PRIO[i];
            end
        end
    end

    assign ro_entry = (ro_fu != FU_NONE) ? fus[ro_fu]  : '0;
    assign ro_pc    = (ro_fu != FU_NONE) ? pcr[ro_fu]  : '0;
    assign ro_imm   = (ro_fu != FU_NONE) ? immr[ro_fu] : '0;
    assign wb_entry = (wb_fu != FU_NONE) ? fus[wb_fu]  : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int u = FU_ALU; u <= FU_JUMP; u++) begin
                fus[u] <= '0;
            end
            for (int r = 0; r < REG_COUNT; r++) begin
                rrs[r] <= FU_NONE;
            end
        end else begin
            if (issue_valid) begin
                fus[req.fu] <= new_entry;
                if (req.dst != '0) begin
                    rrs[req.dst[IDX_W-1:0]] <= req.fu;
                end
            end
            if (ro_fu != FU_NONE) begin   // operands read
                fus[ro_fu].rdy1 <= 1'b0;
                fus[ro_fu].rdy2 <= 1'b0;
            end
            for (int u = FU_ALU; u <= FU_JUMP; u++) begin
                if (fus[u].busy && done_in[u]) begin
                    fus[u].done <= 1'b1;
                end
                // raw wakeup, producer tag dropped so a later write cannot re-arm it
                if (wb_fu != FU_NONE && fus[u].fu1 == wb_fu) begin
                    fus[u].rdy1 <= 1'b1;
                    fus[u].fu1  <= FU_NONE;
                end
                if (wb_fu != FU_NONE && fus[u].fu2 == wb_fu) begin
                    fus[u].rdy2 <= 1'b1;
                    fus[u].fu2  <= FU_NONE;
                end
            end
            if (wb_fu != FU_NONE) begin
                fus[wb_fu] <= '0;
                if (wb_entry.dst != '0) begin
                    rrs[wb_entry.dst[IDX_W-1:0]] <= FU_NONE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            pcr[req.fu]  <= req.pc;
            immr[req.fu] <= req.imm;
        end
    end

endmodule

/* design/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder (
    input  sb_pkg::xlen_t      inst,
    input  sb_pkg::xlen_t      pc,
    input  sb_pkg::xlen_t      imm,
    output sb_pkg::issue_req_t req,
    output sb_pkg::imm_sel_e   imm_sel
);
    import sb_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    fu_e        fu;
    micro_op_e  op;
    logic       use_rd;
    logic       use_rs1;
    logic       use_rs2;
    logic       use_pc;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign alt    = funct7[5];   // sub, sra and srai

    always_comb begin
        fu      = FU_NONE;
        op      = ALU_ADD;
        imm_sel = IMM_NONE;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_pc  = 1'b0;
        case (opcode)
            7'b0110011: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct7 == 7'h01 && !funct3[2]) begin
                    fu = FU_MUL;   // divide half of M not decoded
                    op = micro_op_e'({4'b1100, funct3[1:0]});
                end else if (funct7 == 7'h00 ||
                             (funct7 == 7'h20 && funct3 inside {3'd0, 3'd5})) begin
                    fu = FU_ALU;
                    op = micro_op_e'({2'b00, alt, funct3});
                end
            end
            7'b0010011: begin
                imm_sel = IMM_I;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                if (!(funct3 inside {3'd1, 3'd5}) || funct7 == 7'h00 ||
                    (funct3 == 3'd5 && funct7 == 7'h20)) begin
                    fu = FU_ALU;
                    op = micro_op_e'({2'b01, alt && funct3 == 3'd5, funct3});
                end
            end
            7'b0110111: begin   // lui
                fu      = FU_ALU;
                op      = ALU_LUI;
                imm_sel = IMM_U;
                use_rd  = 1'b1;
            end
            7'b0010111: begin   // auipc
                fu      = FU_ALU;
                op      = ALU_AUIPC;
                imm_sel = IMM_U;
                use_rd  = 1'b1;
                use_pc  = 1'b1;
            end
            7'b1101111: begin   // jal
                fu      = FU_JUMP;
                op      = JUMP_JAL;
                imm_sel = IMM_J;
                use_rd  = 1'b1;
                use_pc  = 1'b1;
            end
            7'b1100111: begin   // jalr
                if (funct3 == 3'd0) begin
                    fu = FU_JUMP;
                end
                op      = JUMP_JALR;
                imm_sel = IMM_I;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_pc  = 1'b1;
            end
            7'b1100011: begin
                if (!(funct3 inside {3'd2, 3'd3})) begin
                    fu = FU_JUMP;
                end
                op      = micro_op_e'({3'b111, funct3});
                imm_sel = IMM_B;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_pc  = 1'b1;
            end
            7'b0000011: begin   // loads
                if (funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
                    fu = FU_MEM;
                end
                op      = micro_op_e'({2'b10, funct3, 1'b0});
                imm_sel = IMM_I;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            7'b0100011: begin   // stores
                if (funct3 inside {3'd0, 3'd1, 3'd2}) begin
                    fu = FU_MEM;
                end
                op      = micro_op_e'({2'b10, funct3, 1'b1});
                imm_sel = IMM_S;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            default: ;
        endcase
        // unknown encodings leave nothing behind
        if (fu == FU_NONE) begin
            op      = ALU_ADD;
            imm_sel = IMM_NONE;
            use_rd  = 1'b0;
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
            use_pc  = 1'b0;
        end
    end

    always_comb begin
        req      = '0;
        req.fu   = fu;
        req.op   = op;
        req.dst  = use_rd  ? inst[11:7]  : '0;
        req.src1 = use_rs1 ? inst[19:15] : '0;
        req.src2 = use_rs2 ? inst[24:20] : '0;
        req.pc   = use_pc ? pc : '0;
        req.imm  = (imm_sel != IMM_NONE) ? imm : '0;
    end

endmodule

/* design/issue_ctrl.sv */
`timescale 1ns/10ps

module issue_ctrl (
    input  logic        clk,
    input  logic        rst,
    input  sb_pkg::fu_e req_fu,
    input  logic        hazard,
    input  logic        jump_done,
    input  logic        is_jump,
    output logic        issue_valid,
    output logic        issue_en
);
    import sb_pkg::*;

    logic branch_pending;   // control transfer still unresolved
    logic flush;

    // the slot under a flush is wrong path, so fetch moves on without accepting it
    assign issue_valid = !flush && !hazard && !branch_pending && (req_fu != FU_NONE);
    assign issue_en    = flush || (!hazard && !branch_pending);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            branch_pending <= 1'b0;
        end else if (issue_valid && req_fu == FU_JUMP) begin
            branch_pending <= 1'b1;
        end else if (jump_done) begin
            branch_pending <= 1'b0;   // issue resumes next cycle
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flush <= 1'b0;
        end else begin
            flush <= jump_done && is_jump;   // single cycle
        end
    end

endmodule

/* design/operand_dispatch.sv */
`timescale 1ns/10ps

module operand_dispatch (
    input  sb_pkg::fu_e       ro_fu,
    input  sb_pkg::fu_entry_t ro_entry,
    input  sb_pkg::xlen_t     ro_pc,
    input  sb_pkg::xlen_t     ro_imm,
    input  sb_pkg::fu_e       wb_fu,
    input  sb_pkg::fu_entry_t wb_entry,
    output sb_pkg::ro_ctrl_t  ro,
    output sb_pkg::wb_ctrl_t  wb
);
    import sb_pkg::*;

    logic is_auipc;

    assign is_auipc = (ro_entry.op == ALU_AUIPC);

    // read operand, one enable for the winning unit
    always_comb begin
        ro = '0;
        if (ro_fu != FU_NONE) begin
            ro.rs1 = ro_entry.src1;
            ro.rs2 = ro_entry.src2;
            ro.pc  = ro_pc;
            ro.imm = ro_imm;
        end
        case (ro_fu)
            FU_ALU: begin
                ro.alu_en      = 1'b1;
                ro.alu_op      = is_auipc ? 4'h0 : ro_entry.op[3:0];   // auipc runs as add
                ro.alu_use_pc  = is_auipc;
                ro.alu_use_imm = ro_entry.op[4];
            end
            FU_MEM: begin
                ro.mem_en    = 1'b1;
                ro.mem_we    = ro_entry.op[0];
                ro.mem_width = ro_entry.op[3:1];
            end
            FU_MUL: begin
                ro.mul_en = 1'b1;
                ro.mul_op = ro_entry.op[1:0];
            end
            FU_JUMP: begin
                ro.jump_en = 1'b1;
                ro.jump_op = ro_entry.op[2:0];   // branch funct3, jal 2, jalr 3
            end
            default: ;
        endcase
    end

    // writeback select
    always_comb begin
        wb           = '0;
        wb.reg_write = (wb_fu != FU_NONE);
        wb.rd        = wb_entry.dst;
        case (wb_fu)
            FU_MEM: begin
                wb.write_sel = WB_MEM;
            end
            FU_MUL: begin
                wb.write_sel = WB_MUL;
            end
            FU_JUMP: begin
                wb.write_sel = WB_JUMP;   // link address
            end
            default: begin
                wb.write_sel = WB_ALU;
            end
        endcase
    end

endmodule

/* design/sb_ctrl_top.sv */
`timescale 1ns/10ps

module sb_ctrl_top #(
    parameter int REG_COUNT = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  sb_pkg::xlen_t    pc,
    input  sb_pkg::xlen_t    inst,
    input  sb_pkg::xlen_t    imm,
    input  sb_pkg::fu_done_t fu_done,
    input  logic             is_jump,
    output logic             issue_en,
    output sb_pkg::imm_sel_e imm_sel,
    output sb_pkg::ro_ctrl_t ro,
    output sb_pkg::wb_ctrl_t wb
);
    import sb_pkg::*;

    issue_req_t req;
    logic       hazard;
    logic       issue_valid;
    fu_e        ro_fu;
    fu_entry_t  ro_entry;
    xlen_t      ro_pc;
    xlen_t      ro_imm;
    fu_e        wb_fu;
    fu_entry_t  wb_entry;

    inst_decoder u_decoder (
        .inst    (inst),
        .pc      (pc),
        .imm     (imm),
        .req     (req),
        .imm_sel (imm_sel)
    );

    issue_ctrl u_issue (
        .clk         (clk),
        .rst         (rst),
        .req_fu      (req.fu),
        .hazard      (hazard),
        .jump_done   (fu_done.jump),
        .is_jump     (is_jump),
        .issue_valid (issue_valid),
        .issue_en    (issue_en)
    );

    fu_status_table #(
        .REG_COUNT (REG_COUNT)
    ) u_table (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .issue_valid (issue_valid),
        .fu_done     (fu_done),
        .hazard      (hazard),
        .ro_fu       (ro_fu),
        .ro_entry    (ro_entry),
        .ro_pc       (ro_pc),
        .ro_imm      (ro_imm),
        .wb_fu       (wb_fu),
        .wb_entry    (wb_entry)
    );

    operand_dispatch u_dispatch (
        .ro_fu    (ro_fu),
        .ro_entry (ro_entry),
        .ro_pc    (ro_pc),
        .ro_imm   (ro_imm),
        .wb_fu    (wb_fu),
        .wb_entry (wb_entry),
        .ro       (ro),
        .wb       (wb)
    );

endmodule

/* design/sb_pkg.sv */
package sb_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        FU_NONE = 3'd0,
        FU_ALU  = 3'd1,
        FU_MEM  = 3'd2,
        FU_MUL  = 3'd3,
        FU_JUMP = 3'd4
    } fu_e;

    // alu {0, imm, alt, funct3}, mem {10, funct3, write}, mul {1100, funct3[1:0]},
    // jump {111, funct3} with jal and jalr in the two unused branch slots
    typedef enum logic [5:0] {
        ALU_ADD    = 6'h00, ALU_SUB    = 6'h08,
        ALU_SLL    = 6'h01, ALU_SLT    = 6'h02,
        ALU_SLTU   = 6'h03, ALU_XOR    = 6'h04,
        ALU_SRL    = 6'h05, ALU_SRA    = 6'h0d,
        ALU_OR     = 6'h06, ALU_AND    = 6'h07,
        ALU_ADDI   = 6'h10, ALU_SLLI   = 6'h11,
        ALU_SLTI   = 6'h12, ALU_SLTIU  = 6'h13,
        ALU_XORI   = 6'h14, ALU_SRLI   = 6'h15,
        ALU_SRAI   = 6'h1d, ALU_ORI    = 6'h16,
        ALU_ANDI   = 6'h17, ALU_LUI    = 6'h19,
        ALU_AUIPC  = 6'h1a,
        MEM_LB     = 6'h20, MEM_SB     = 6'h21,
        MEM_LH     = 6'h22, MEM_SH     = 6'h23,
        MEM_LW     = 6'h24, MEM_SW     = 6'h25,
        MEM_LBU    = 6'h28, MEM_LHU    = 6'h2a,
        MUL_MUL    = 6'h30, MUL_MULH   = 6'h31,
        MUL_MULHSU = 6'h32, MUL_MULHU  = 6'h33,
        JUMP_BEQ   = 6'h38, JUMP_BNE   = 6'h39,
        JUMP_JAL   = 6'h3a, JUMP_JALR  = 6'h3b,
        JUMP_BLT   = 6'h3c, JUMP_BGE   = 6'h3d,
        JUMP_BLTU  = 6'h3e, JUMP_BGEU  = 6'h3f
    } micro_op_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_B    = 3'd2,
        IMM_J    = 3'd3,
        IMM_S    = 3'd4,
        IMM_U    = 3'd5
    } imm_sel_e;

    typedef enum logic [2:0] {
        WB_ALU  = 3'd0,
        WB_MEM  = 3'd1,
        WB_MUL  = 3'd2,
        WB_JUMP = 3'd4
    } wb_sel_e;

    typedef struct packed {
        fu_e       fu;
        micro_op_e op;
        reg_idx_t  dst;
        reg_idx_t  src1;
        reg_idx_t  src2;
        xlen_t     pc;
        xlen_t     imm;
    } issue_req_t;

    typedef struct packed {
        logic      busy;
        micro_op_e op;
        reg_idx_t  dst;
        reg_idx_t  src1;
        reg_idx_t  src2;
        fu_e       fu1;   // producer of src1 while waiting
        fu_e       fu2;
        logic      rdy1;
        logic      rdy2;
        logic      done;
    } fu_entry_t;

    typedef struct packed {
        logic jump;
        logic mul;
        logic mem;
        logic alu;
    } fu_done_t;

    typedef struct packed {
        logic       alu_en;
        logic       mem_en;
        logic       mul_en;
        logic       jump_en;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        xlen_t      pc;
        xlen_t      imm;
        logic [3:0] alu_op;
        logic       alu_use_pc;
        logic       alu_use_imm;
        logic       mem_we;
        logic [2:0] mem_width;   // funct3 of the load or store
        logic [1:0] mul_op;
        logic [2:0] jump_op;
    } ro_ctrl_t;

    typedef struct packed {
        logic     reg_write;
        wb_sel_e  write_sel;
        reg_idx_t rd;
    } wb_ctrl_t;

endpackage

/* sources.f */
+incdir+verification
design/sb_pkg.sv
design/inst_decoder.sv
design/issue_ctrl.sv
design/fu_status_table.sv
design/operand_dispatch.sv
design/sb_ctrl_top.sv
verification/sb_ctrl_tb.sv

/* verification/sb_ctrl_tests.svh */
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_IMM    = 7'b0010011;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;

function automatic xlen_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, rs1,
                                input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic xlen_t enc_i(input logic [11:0] v, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd,
                                input logic [6:0] opc);
    return {v, rs1, f3, rd, opc};
endfunction

function automatic xlen_t enc_s(input logic [11:0] v, input reg_idx_t rs2, rs1,
                                input logic [2:0] f3);
    return {v[11:5], rs2, rs1, f3, v[4:0], OPC_STORE};
endfunction

function automatic xlen_t enc_b(input logic [12:0] v, input reg_idx_t rs2, rs1,
                                input logic [2:0] f3);
    return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], OPC_BRANCH};
endfunction

function automatic xlen_t rand_imm12();
    logic [31:0] r;
    r = next_random();
    return {{20{r[11]}}, r[11:0]};
endfunction

task automatic present(input xlen_t i, input xlen_t p, input xlen_t v);
    inst = i;
    pc   = p;
    imm  = v;
endtask

task automatic idle();
    present('0, '0, '0);
endtask

// pulse one done, expect its writeback the cycle after
task automatic retire(input wb_sel_e sel, input reg_idx_t rd);
    case (sel)
        WB_ALU: fu_done.alu = 1'b1;
        WB_MEM: fu_done.mem = 1'b1;
        WB_MUL: fu_done.mul = 1'b1;
        default: fu_done.jump = 1'b1;
    endcase
    @(negedge clk);
    check_eq("wb.reg_write", wb.reg_write, 1'b1);
    check_eq("wb.write_sel", wb.write_sel, sel);
    check_eq("wb.rd", wb.rd, rd);
    fu_done = '0;
    @(negedge clk);
    check_eq("wb.reg_write after writeback", wb.reg_write, 1'b0);
endtask

task automatic reset_state();
    @(negedge clk);
    check_eq("alu_en after reset", ro.alu_en, 1'b0);
    check_eq("mem_en after reset", ro.mem_en, 1'b0);
    check_eq("mul_en after reset", ro.mul_en, 1'b0);
    check_eq("jump_en after reset", ro.jump_en, 1'b0);
    check_eq("reg_write after reset", wb.reg_write, 1'b0);
    check_eq("issue_en after reset", issue_en, 1'b1);
endtask

task automatic alu_round_trip();
    reg_idx_t rd;
    reg_idx_t rs1;
    xlen_t    v;
    rd  = fresh_reg(32'h1);
    rs1 = fresh_reg(32'h1 | (32'h1 << rd));
    v   = rand_imm12();
    present(enc_i(v[11:0], rs1, 3'd0, rd, OPC_IMM), 32'h100, v);   // addi
    @(negedge clk);
    check_eq("addi alu_en", ro.alu_en, 1'b1);
    check_eq("addi alu_use_imm", ro.alu_use_imm, 1'b1);
    check_eq("addi alu_use_pc", ro.alu_use_pc, 1'b0);
    check_eq("addi alu_op", ro.alu_op, 4'h0);
    check_eq("addi rs1", ro.rs1, rs1);
    check_eq("addi imm", ro.imm, v);
    check_eq("addi imm_sel", imm_sel, IMM_I);
    idle();
    @(negedge clk);
    check_eq("alu_en is one cycle", ro.alu_en, 1'b0);
    retire(WB_ALU, rd);
endtask

task automatic raw_wait();
    reg_idx_t rd;
    reg_idx_t a;
    reg_idx_t b;
    reg_idx_t d;
    reg_idx_t e;
    rd = fresh_reg(32'h1);
    a  = fresh_reg(32'h1 | (32'h1 << rd));
    b  = fresh_reg(32'h1 | (32'h1 << rd) | (32'h1 << a));
    d  = fresh_reg(32'h1 | (32'h1 << rd) | (32'h1 << a) | (32'h1 << b));
    e  = fresh_reg(32'h1 | (32'h1 << rd) | (32'h1 << d));
    present(enc_r(7'h01, b, a, 3'd0, rd), '0, '0);   // mul rd, a, b
    @(negedge clk);
    check_eq("mul mul_en", ro.mul_en, 1'b1);
    check_eq("mul mul_op", ro.mul_op, 2'd0);
    check_eq("mul rs1", ro.rs1, a);
    check_eq("mul rs2", ro.rs2, b);
    present(enc_r(7'h00, e, rd, 3'd0, d), '0, '0);   // add d, rd, e
    @(negedge clk);
    check_eq("add waits on mul", ro.alu_en, 1'b0);
    idle();
    repeat (2) begin
        @(negedge clk);
        check_eq("add still waiting", ro.alu_en, 1'b0);
    end
    fu_done.mul = 1'b1;
    @(negedge clk);
    check_eq("mul wb.reg_write", wb.reg_write, 1'b1);
    check_eq("mul wb.write_sel", wb.write_sel, WB_MUL);
    check_eq("mul wb.rd", wb.rd, rd);
    check_eq("add waits during writeback", ro.alu_en, 1'b0);
    fu_done = '0;
    @(negedge clk);
    check_eq("add alu_en after wakeup", ro.alu_en, 1'b1);
    check_eq("add rs1", ro.rs1, rd);
    check_eq("add rs2", ro.rs2, e);
    check_eq("add alu_use_imm", ro.alu_use_imm, 1'b0);
    retire(WB_ALU, d);
endtask

task automatic issue_stalls();
    reg_idx_t ra;
    reg_idx_t rx;
    reg_idx_t ry;
    reg_idx_t rd2;
    xlen_t    v;
    ra  = fresh_reg(32'h1);
    rx  = fresh_reg(32'h1 | (32'h1 << ra));
    ry  = fresh_reg(32'h1 | (32'h1 << ra) | (32'h1 << rx));
    rd2 = fresh_reg(32'h1 | (32'h1 << ra) | (32'h1 << rx) | (32'h1 << ry));
    v   = rand_imm12();
    present(enc_r(7'h00, ry, rx, 3'd0, ra), '0, '0);   // add ra, rx, ry
    @(negedge clk);
    check_eq("first add alu_en", ro.alu_en, 1'b1);
    present(enc_i(v[11:0], 5'd0, 3'd0, rd2, OPC_IMM), '0, v);   // alu busy
    @(negedge clk);
    check_eq("structural issue_en", issue_en, 1'b0);
    check_eq("structural alu_en", ro.alu_en, 1'b0);
    present(enc_r(7'h01, ry, rx, 3'd0, ra), '0, '0);   // mul ra, waw on ra
    @(negedge clk);
    check_eq("waw issue_en", issue_en, 1'b0);
    check_eq("waw mul_en", ro.mul_en, 1'b0);
    fu_done.alu = 1'b1;
    @(negedge clk);
    check_eq("add wb.reg_write", wb.reg_write, 1'b1);
    check_eq("add wb.rd", wb.rd, ra);
    check_eq("waw held until writeback", issue_en, 1'b0);
    fu_done = '0;
    @(negedge clk);
    check_eq("waw released issue_en", issue_en, 1'b1);
    check_eq("mul not yet issued", ro.mul_en, 1'b0);
    @(negedge clk);
    check_eq("released mul_en", ro.mul_en, 1'b1);
    check_eq("released mul rs1", ro.rs1, rx);
    present(enc_i(v[11:0], 5'd0, 3'd0, rd2, OPC_IMM), '0, v);
    @(negedge clk);
    check_eq("released addi alu_en", ro.alu_en, 1'b1);
    check_eq("released addi imm", ro.imm, v);
    idle();
    retire(WB_ALU, rd2);
    retire(WB_MUL, ra);
endtask

task automatic jump_control();
    reg_idx_t    r1;
    reg_idx_t    r2;
    reg_idx_t    rd;
    logic [31:0] r;
    xlen_t       off;
    r1  = fresh_reg(32'h1);
    r2  = fresh_reg(32'h1 | (32'h1 << r1));
    rd  = fresh_reg(32'h1);
    r   = next_random();
    off = {{19{r[12]}}, r[12:1], 1'b0};   // branch offsets are even
    present(enc_b(off[12:0], r2, r1, 3'd0), 32'h200, off);   // beq
    @(negedge clk);
    check_eq("beq jump_en", ro.jump_en, 1'b1);
    check_eq("beq jump_op", ro.jump_op, 3'd0);
    check_eq("beq rs1", ro.rs1, r1);
    check_eq("beq rs2", ro.rs2, r2);
    check_eq("beq pc", ro.pc, 32'h200);
    check_eq("beq imm", ro.imm, off);
    check_eq("beq imm_sel", imm_sel, IMM_B);
    check_eq("issue_en while branch pending", issue_en, 1'b0);
    present(enc_i(12'h001, 5'd0, 3'd0, rd, OPC_IMM), '0, 32'h1);
    repeat (2) begin
        @(negedge clk);
        check_eq("issue_en until jump done", issue_en, 1'b0);
        check_eq("no alu dispatch while pending", ro.alu_en, 1'b0);
    end
    fu_done.jump = 1'b1;
    is_jump      = 1'b1;
    @(negedge clk);
    check_eq("issue_en during flush", issue_en, 1'b1);
    check_eq("beq wb.write_sel", wb.write_sel, WB_JUMP);
    check_eq("beq wb.rd", wb.rd, 5'd0);
    fu_done = '0;
    is_jump = 1'b0;
    @(negedge clk);
    check_eq("flushed slot not dispatched", ro.alu_en, 1'b0);
    check_eq("issue_en after flush", issue_en, 1'b1);
    @(negedge clk);
    check_eq("issue resumes alu_en", ro.alu_en, 1'b1);
    idle();
    retire(WB_ALU, rd);
endtask

task automatic memory_ops();
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    v;
    rd  = fresh_reg(32'h1);
    rs1 = fresh_reg(32'h1 | (32'h1 << rd));
    rs2 = fresh_reg(32'h1 | (32'h1 << rs1));
    v   = rand_imm12();
    present(enc_i(v[11:0], rs1, 3'd2, rd, OPC_LOAD), '0, v);   // lw
    @(negedge clk);
    check_eq("lw mem_en", ro.mem_en, 1'b1);
    check_eq("lw mem_we", ro.mem_we, 1'b0);
    check_eq("lw mem_width", ro.mem_width, 3'd2);
    check_eq("lw imm_sel", imm_sel, IMM_I);
    check_eq("lw rs1", ro.rs1, rs1);
    check_eq("lw imm", ro.imm, v);
    idle();
    retire(WB_MEM, rd);
    v = rand_imm12();
    present(enc_s(v[11:0], rs2, rs1, 3'd2), '0, v);   // sw
    @(negedge clk);
    check_eq("sw mem_en", ro.mem_en, 1'b1);
    check_eq("sw mem_we", ro.mem_we, 1'b1);
    check_eq("sw mem_width", ro.mem_width, 3'd2);
    check_eq("sw imm_sel", imm_sel, IMM_S);
    check_eq("sw rs1", ro.rs1, rs1);
    check_eq("sw rs2", ro.rs2, rs2);
    check_eq("sw imm", ro.imm, v);
    idle();
    retire(WB_MEM, 5'd0);   // stores carry no destination
endtask

/* verification/sb_ctrl_tb.sv */
`timescale 1ns/10ps

module sb_ctrl_tb;
    import sb_pkg::*;

    localparam int REG_COUNT    = 32;
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES  = 40;   // six directed tests need 38 cycles
    localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + TEST_CYCLES);

    logic       clk = 1'b0;
    logic       rst;
    xlen_t      pc;
    xlen_t      inst;
    xlen_t      imm;
    fu_done_t   fu_done;
    logic       is_jump;
    logic       issue_en;
    imm_sel_e   imm_sel;
    ro_ctrl_t   ro;
    wb_ctrl_t   wb;

    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    logic [31:0] rng_state   = 32'haf7a_c0c0;

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    sb_ctrl_top #(
        .REG_COUNT (REG_COUNT)
    ) sb_ctrl_top_inst (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .inst     (inst),
        .imm      (imm),
        .fu_done  (fu_done),
        .is_jump  (is_jump),
        .issue_en (issue_en),
        .imm_sel  (imm_sel),
        .ro       (ro),
        .wb       (wb)
    );

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // random nonzero register not set in the used mask
    function automatic reg_idx_t fresh_reg(input logic [31:0] used);
        reg_idx_t r;
        r = reg_idx_t'(next_random() % 31 + 1);
        while (used[r]) begin
            r = reg_idx_t'(next_random() % 31 + 1);
        end
        return r;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got,
                            input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    `include "sb_ctrl_tests.svh"

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        pc      = '0;
        inst    = '0;   // opcode 0 decodes to no unit
        imm     = '0;
        fu_done = '0;
        is_jump = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_state();
        alu_round_trip();
        raw_wait();
        issue_stalls();
        jump_control();
        memory_ops();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
